// ==== src/core_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Core encodings
// Pipeline encodings seen by the retirement trace: next-PC source,
// exception PC kind, privilege level and load/store access size
//////////////////////////////////////////////////////////////////////

package core_pkg;

  // Next-PC source chosen by the controller
  typedef enum logic [2:0] {
    PC_BOOT = 3'b000,
    PC_JUMP = 3'b001,
    PC_EXC  = 3'b010,
    PC_ERET = 3'b011,
    PC_DRET = 3'b100
  } pc_sel_e;

  // Kind of exception PC when PC_EXC is selected
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'b00,
    EXC_PC_IRQ     = 2'b01,
    EXC_PC_DBD     = 2'b10,
    EXC_PC_DBG_EXC = 2'b11
  } exc_pc_sel_e;

  // Privilege levels, RISC-V encoding
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Load/store access size
  typedef enum logic [1:0] {
    DATA_WORD = 2'b00,
    DATA_HALF = 2'b01,
    DATA_BYTE = 2'b10
  } data_type_e;

endpackage

// ==== src/trace_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Trace packet definitions
// Field widths of the retirement trace packet and the byte mask type
//////////////////////////////////////////////////////////////////////

package trace_pkg;

  // Register and address width
  localparam int unsigned XLEN = 32;

  // Register index width
  localparam int unsigned REG_ADDR_W = 5;

  // Compressed instruction width
  localparam int unsigned CINSN_W = 16;

  // Default order counter width
  localparam int unsigned ORDER_W_DEFAULT = 64;

  // One bit per byte lane of a data word
  typedef logic [XLEN/8-1:0] byte_mask_t;

endpackage

// ==== src/operand_if.sv ====
//////////////////////////////////////////////////////////////////////
// Operand interface
// Instruction word and source operands of the instruction in flight
//////////////////////////////////////////////////////////////////////

interface operand_if;

  logic [trace_pkg::XLEN-1:0]       insn;
  logic [trace_pkg::REG_ADDR_W-1:0] rs1_addr;
  logic [trace_pkg::REG_ADDR_W-1:0] rs2_addr;
  logic [trace_pkg::XLEN-1:0]       rs1_data;
  logic [trace_pkg::XLEN-1:0]       rs2_data;

  // Capture side drives, packer side reads
  modport src (
    output insn, rs1_addr, rs2_addr, rs1_data, rs2_data
  );

  modport dst (
    input insn, rs1_addr, rs2_addr, rs1_data, rs2_data
  );

endinterface

// ==== src/trace_ctrl_tracker.sv ====
//////////////////////////////////////////////////////////////////////
// Trace control tracker
// Tracks the decode-to-retire window and the first instruction
// retired after a trap entry
//////////////////////////////////////////////////////////////////////

module trace_ctrl_tracker (
  input  logic                     clk,
  input  logic                     rst_ni,
  input  logic                     instr_new_i,
  input  logic                     instr_ret_i,
  input  logic                     pc_set_i,
  input  core_pkg::pc_sel_e        pc_mux_i,
  input  core_pkg::exc_pc_sel_e    exc_pc_mux_i,
  output logic                     window_o,
  output logic                     intr_o
);

  logic window_q;
  logic trap_d, trap_q;
  logic trap_entry;

  // Window opens on a new instruction and stays open until retire
  assign window_o = instr_new_i | window_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      window_q <= 1'b0;
    end else if (instr_ret_i) begin
      window_q <= 1'b0;
    end else begin
      window_q <= window_o;
    end
  end

  // PC redirected into a trap handler, debug entries excluded
  assign trap_entry = pc_set_i && (pc_mux_i == core_pkg::PC_EXC) &&
                      ((exc_pc_mux_i == core_pkg::EXC_PC_EXC) ||
                       (exc_pc_mux_i == core_pkg::EXC_PC_IRQ));

  always_comb begin
    trap_d = trap_q;
    if (trap_entry) begin
      trap_d = 1'b1;
    end else if (trap_q && instr_ret_i) begin
      // First handler instruction has retired
      trap_d = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_q <= 1'b0;
    end else begin
      trap_q <= trap_d;
    end
  end

  assign intr_o = trap_q & window_o;

endmodule

// ==== src/trace_operand_capture.sv ====
//////////////////////////////////////////////////////////////////////
// Trace operand capture
// Picks the instruction word and holds it with the source operands
// from decode until the next instruction enters
//////////////////////////////////////////////////////////////////////

module trace_operand_capture (
  input  logic                             clk,
  input  logic                             rst_ni,
  input  logic                             instr_new_i,
  input  logic [trace_pkg::XLEN-1:0]       instr_rdata_i,
  input  logic [trace_pkg::CINSN_W-1:0]    instr_rdata_c_i,
  input  logic                             instr_is_compressed_i,
  input  logic [trace_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [trace_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  input  logic [trace_pkg::XLEN-1:0]       rs1_rdata_i,
  input  logic [trace_pkg::XLEN-1:0]       rs2_rdata_i,
  operand_if.src                           op
);

  logic [trace_pkg::XLEN-1:0]       insn_sel;
  logic [trace_pkg::XLEN-1:0]       insn_q;
  logic [trace_pkg::REG_ADDR_W-1:0] rs1_addr_q, rs2_addr_q;
  logic [trace_pkg::XLEN-1:0]       rs1_data_q, rs2_data_q;

  // Compressed encodings are zero-extended to a full word
  assign insn_sel = instr_is_compressed_i ?
                    {{(trace_pkg::XLEN-trace_pkg::CINSN_W){1'b0}}, instr_rdata_c_i} :
                    instr_rdata_i;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      insn_q     <= '0;
      rs1_addr_q <= '0;
      rs2_addr_q <= '0;
      rs1_data_q <= '0;
      rs2_data_q <= '0;
    end else if (instr_new_i) begin
      insn_q     <= insn_sel;
      rs1_addr_q <= rs1_addr_i;
      rs2_addr_q <= rs2_addr_i;
      rs1_data_q <= rs1_rdata_i;
      rs2_data_q <= rs2_rdata_i;
    end
  end

  // Live values in the decode cycle, held copy afterwards
  assign op.insn     = instr_new_i ? insn_sel    : insn_q;
  assign op.rs1_addr = instr_new_i ? rs1_addr_i  : rs1_addr_q;
  assign op.rs2_addr = instr_new_i ? rs2_addr_i  : rs2_addr_q;
  assign op.rs1_data = instr_new_i ? rs1_rdata_i : rs1_data_q;
  assign op.rs2_data = instr_new_i ? rs2_rdata_i : rs2_data_q;

endmodule

// ==== src/trace_packer.sv ====
//////////////////////////////////////////////////////////////////////
// Trace packer
// Holds destination and memory fields per instruction and registers
// one trace packet per retired instruction
//////////////////////////////////////////////////////////////////////

module trace_packer #(
  parameter int unsigned OrderWidth = trace_pkg::ORDER_W_DEFAULT
) (
  input  logic                             clk,
  input  logic                             rst_ni,
  input  logic                             window_i,
  input  logic                             intr_i,
  operand_if.dst                           op,
  input  logic                             instr_ret_i,
  input  logic                             illegal_insn_i,
  input  core_pkg::priv_lvl_e              priv_mode_i,
  input  logic [trace_pkg::XLEN-1:0]       pc_id_i,
  input  logic [trace_pkg::XLEN-1:0]       pc_if_i,
  input  logic [trace_pkg::REG_ADDR_W-1:0] rd_addr_i,
  input  logic [trace_pkg::XLEN-1:0]       rd_wdata_i,
  input  logic                             rd_we_i,
  input  logic                             lsu_data_valid_i,
  input  core_pkg::data_type_e             data_type_i,
  input  logic                             data_we_i,
  input  logic [trace_pkg::XLEN-1:0]       mem_addr_i,
  input  logic [trace_pkg::XLEN-1:0]       mem_rdata_i,
  input  logic [trace_pkg::XLEN-1:0]       mem_wdata_i,
  output logic                             trace_valid_o,
  output logic [OrderWidth-1:0]            trace_order_o,
  output logic [trace_pkg::XLEN-1:0]       trace_insn_o,
  output logic                             trace_trap_o,
  output logic                             trace_intr_o,
  output core_pkg::priv_lvl_e              trace_mode_o,
  output logic [trace_pkg::REG_ADDR_W-1:0] trace_rs1_addr_o,
  output logic [trace_pkg::REG_ADDR_W-1:0] trace_rs2_addr_o,
  output logic [trace_pkg::XLEN-1:0]       trace_rs1_rdata_o,
  output logic [trace_pkg::XLEN-1:0]       trace_rs2_rdata_o,
  output logic [trace_pkg::REG_ADDR_W-1:0] trace_rd_addr_o,
  output logic [trace_pkg::XLEN-1:0]       trace_rd_wdata_o,
  output logic [trace_pkg::XLEN-1:0]       trace_pc_rdata_o,
  output logic [trace_pkg::XLEN-1:0]       trace_pc_wdata_o,
  output logic [trace_pkg::XLEN-1:0]       trace_mem_addr_o,
  output trace_pkg::byte_mask_t            trace_mem_rmask_o,
  output trace_pkg::byte_mask_t            trace_mem_wmask_o,
  output logic [trace_pkg::XLEN-1:0]       trace_mem_rdata_o,
  output logic [trace_pkg::XLEN-1:0]       trace_mem_wdata_o
);

  logic [trace_pkg::REG_ADDR_W-1:0] rd_addr_d, rd_addr_q;
  logic [trace_pkg::XLEN-1:0]       rd_wdata_d, rd_wdata_q;
  logic                             mem_take;
  trace_pkg::byte_mask_t            byte_mask;
  trace_pkg::byte_mask_t            rmask_d, rmask_q, wmask_d, wmask_q;
  logic [trace_pkg::XLEN-1:0]       mem_addr_d, mem_addr_q;
  logic [trace_pkg::XLEN-1:0]       mem_rdata_d, mem_rdata_q;
  logic [trace_pkg::XLEN-1:0]       mem_wdata_d, mem_wdata_q;

  //////////////////////////////////////////////////////////////////////
  // Destination and memory hold
  //////////////////////////////////////////////////////////////////////

  // No write reports nothing, x0 keeps its address but reads zero
  always_comb begin
    rd_addr_d  = rd_addr_q;
    rd_wdata_d = rd_wdata_q;
    if (window_i) begin
      if (!rd_we_i) begin
        rd_addr_d  = '0;
        rd_wdata_d = '0;
      end else begin
        rd_addr_d  = rd_addr_i;
        rd_wdata_d = (rd_addr_i == '0) ? '0 : rd_wdata_i;
      end
    end
  end

  always_comb begin
    unique case (data_type_i)
      core_pkg::DATA_WORD: byte_mask = 4'b1111;
      core_pkg::DATA_HALF: byte_mask = 4'b0011;
      core_pkg::DATA_BYTE: byte_mask = 4'b0001;
      default:             byte_mask = 4'b0000;
    endcase
  end

  // Memory fields only change on a completed access
  assign mem_take    = window_i & lsu_data_valid_i;
  assign mem_addr_d  = mem_take ? mem_addr_i  : mem_addr_q;
  assign mem_rdata_d = mem_take ? mem_rdata_i : mem_rdata_q;
  assign mem_wdata_d = mem_take ? mem_wdata_i : mem_wdata_q;
  assign rmask_d     = mem_take ? byte_mask : rmask_q;
  assign wmask_d     = mem_take ? (data_we_i ? byte_mask : '0) : wmask_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_addr_q   <= '0;
      rd_wdata_q  <= '0;
      mem_addr_q  <= '0;
      mem_rdata_q <= '0;
      mem_wdata_q <= '0;
      rmask_q     <= '0;
      wmask_q     <= '0;
    end else begin
      rd_addr_q   <= rd_addr_d;
      rd_wdata_q  <= rd_wdata_d;
      mem_addr_q  <= mem_addr_d;
      mem_rdata_q <= mem_rdata_d;
      mem_wdata_q <= mem_wdata_d;
      rmask_q     <= rmask_d;
      wmask_q     <= wmask_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Packet registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      trace_valid_o <= 1'b0;
      trace_order_o <= '0;
      trace_trap_o  <= 1'b0;
      trace_intr_o  <= 1'b0;
      trace_mode_o  <= core_pkg::PRIV_LVL_M;
    end else begin
      trace_valid_o <= instr_ret_i;
      // Order counts packets already sent
      trace_order_o <= trace_order_o + OrderWidth'(trace_valid_o);
      trace_trap_o  <= illegal_insn_i;
      trace_intr_o  <= intr_i;
      trace_mode_o  <= priv_mode_i;
    end
  end

  always_ff @(posedge clk) begin
    trace_insn_o      <= op.insn;
    trace_rs1_addr_o  <= op.rs1_addr;
    trace_rs2_addr_o  <= op.rs2_addr;
    trace_rs1_rdata_o <= op.rs1_data;
    trace_rs2_rdata_o <= op.rs2_data;
    trace_rd_addr_o   <= rd_addr_d;
    trace_rd_wdata_o  <= rd_wdata_d;
    trace_pc_rdata_o  <= pc_id_i;
    trace_pc_wdata_o  <= pc_if_i;
    trace_mem_addr_o  <= mem_addr_d;
    trace_mem_rmask_o <= rmask_d;
    trace_mem_wmask_o <= wmask_d;
    trace_mem_rdata_o <= mem_rdata_d;
    trace_mem_wdata_o <= mem_wdata_d;
  end

endmodule

// ==== src/retire_trace.sv ====
//////////////////////////////////////////////////////////////////////
// Retirement trace
// Builds one trace packet per retired instruction from pipeline events
//////////////////////////////////////////////////////////////////////

module retire_trace #(
  parameter int unsigned OrderWidth = trace_pkg::ORDER_W_DEFAULT
) (
  input  logic                             clk,
  input  logic                             rst_ni,
  // Pipeline events
  input  logic                             instr_new_i,
  input  logic                             instr_ret_i,
  input  logic [trace_pkg::XLEN-1:0]       instr_rdata_i,
  input  logic [trace_pkg::CINSN_W-1:0]    instr_rdata_c_i,
  input  logic                             instr_is_compressed_i,
  input  logic                             illegal_insn_i,
  input  logic [trace_pkg::XLEN-1:0]       pc_id_i,
  input  logic [trace_pkg::XLEN-1:0]       pc_if_i,
  input  core_pkg::priv_lvl_e              priv_mode_i,
  input  logic [trace_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [trace_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  input  logic [trace_pkg::XLEN-1:0]       rs1_rdata_i,
  input  logic [trace_pkg::XLEN-1:0]       rs2_rdata_i,
  input  logic [trace_pkg::REG_ADDR_W-1:0] rd_addr_i,
  input  logic [trace_pkg::XLEN-1:0]       rd_wdata_i,
  input  logic                             rd_we_i,
  input  logic                             lsu_data_valid_i,
  input  core_pkg::data_type_e             data_type_i,
  input  logic                             data_we_i,
  input  logic [trace_pkg::XLEN-1:0]       mem_addr_i,
  input  logic [trace_pkg::XLEN-1:0]       mem_rdata_i,
  input  logic [trace_pkg::XLEN-1:0]       mem_wdata_i,
  input  logic                             pc_set_i,
  input  core_pkg::pc_sel_e                pc_mux_i,
  input  core_pkg::exc_pc_sel_e            exc_pc_mux_i,
  // Trace packet
  output logic                             trace_valid_o,
  output logic [OrderWidth-1:0]            trace_order_o,
  output logic [trace_pkg::XLEN-1:0]       trace_insn_o,
  output logic                             trace_trap_o,
  output logic                             trace_intr_o,
  output core_pkg::priv_lvl_e              trace_mode_o,
  output logic [trace_pkg::REG_ADDR_W-1:0] trace_rs1_addr_o,
  output logic [trace_pkg::REG_ADDR_W-1:0] trace_rs2_addr_o,
  output logic [trace_pkg::XLEN-1:0]       trace_rs1_rdata_o,
  output logic [trace_pkg::XLEN-1:0]       trace_rs2_rdata_o,
  output logic [trace_pkg::REG_ADDR_W-1:0] trace_rd_addr_o,
  output logic [trace_pkg::XLEN-1:0]       trace_rd_wdata_o,
  output logic [trace_pkg::XLEN-1:0]       trace_pc_rdata_o,
  output logic [trace_pkg::XLEN-1:0]       trace_pc_wdata_o,
  output logic [trace_pkg::XLEN-1:0]       trace_mem_addr_o,
  output trace_pkg::byte_mask_t            trace_mem_rmask_o,
  output trace_pkg::byte_mask_t            trace_mem_wmask_o,
  output logic [trace_pkg::XLEN-1:0]       trace_mem_rdata_o,
  output logic [trace_pkg::XLEN-1:0]       trace_mem_wdata_o
);

  logic window;
  logic intr;

  operand_if operands ();

  trace_ctrl_tracker i_ctrl_tracker (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .instr_new_i  (instr_new_i),
    .instr_ret_i  (instr_ret_i),
    .pc_set_i     (pc_set_i),
    .pc_mux_i     (pc_mux_i),
    .exc_pc_mux_i (exc_pc_mux_i),
    .window_o     (window),
    .intr_o       (intr)
  );

  trace_operand_capture i_operand_capture (
    .clk                   (clk),
    .rst_ni                (rst_ni),
    .instr_new_i           (instr_new_i),
    .instr_rdata_i         (instr_rdata_i),
    .instr_rdata_c_i       (instr_rdata_c_i),
    .instr_is_compressed_i (instr_is_compressed_i),
    .rs1_addr_i            (rs1_addr_i),
    .rs2_addr_i            (rs2_addr_i),
    .rs1_rdata_i           (rs1_rdata_i),
    .rs2_rdata_i           (rs2_rdata_i),
    .op                    (operands.src)
  );

  trace_packer #(
    .OrderWidth (OrderWidth)
  ) i_packer (
    .clk               (clk),
    .rst_ni            (rst_ni),
    .window_i          (window),
    .intr_i            (intr),
    .op                (operands.dst),
    .instr_ret_i       (instr_ret_i),
    .illegal_insn_i    (illegal_insn_i),
    .priv_mode_i       (priv_mode_i),
    .pc_id_i           (pc_id_i),
    .pc_if_i           (pc_if_i),
    .rd_addr_i         (rd_addr_i),
    .rd_wdata_i        (rd_wdata_i),
    .rd_we_i           (rd_we_i),
    .lsu_data_valid_i  (lsu_data_valid_i),
    .data_type_i       (data_type_i),
    .data_we_i         (data_we_i),
    .mem_addr_i        (mem_addr_i),
    .mem_rdata_i       (mem_rdata_i),
    .mem_wdata_i       (mem_wdata_i),
    .trace_valid_o     (trace_valid_o),
    .trace_order_o     (trace_order_o),
    .trace_insn_o      (trace_insn_o),
    .trace_trap_o      (trace_trap_o),
    .trace_intr_o      (trace_intr_o),
    .trace_mode_o      (trace_mode_o),
    .trace_rs1_addr_o  (trace_rs1_addr_o),
    .trace_rs2_addr_o  (trace_rs2_addr_o),
    .trace_rs1_rdata_o (trace_rs1_rdata_o),
    .trace_rs2_rdata_o (trace_rs2_rdata_o),
    .trace_rd_addr_o   (trace_rd_addr_o),
    .trace_rd_wdata_o  (trace_rd_wdata_o),
    .trace_pc_rdata_o  (trace_pc_rdata_o),
    .trace_pc_wdata_o  (trace_pc_wdata_o),
    .trace_mem_addr_o  (trace_mem_addr_o),
    .trace_mem_rmask_o (trace_mem_rmask_o),
    .trace_mem_wmask_o (trace_mem_wmask_o),
    .trace_mem_rdata_o (trace_mem_rdata_o),
    .trace_mem_wdata_o (trace_mem_wdata_o)
  );

endmodule

// ==== tb/trace_checker.sv ====
//////////////////////////////////////////////////////////////////////
// Trace checker
// Compares every trace packet with the expected record of its test
//////////////////////////////////////////////////////////////////////

module trace_checker #(
  parameter int MaxTests = 32,
  parameter int Timeout  = 40
) (
  input  logic        clk,
  input  logic        rst_ni,
  input  logic        ret_i,
  input  logic        valid_i,
  input  logic [63:0] order_i,
  input  logic [31:0] insn_i,
  input  logic        trap_i,
  input  logic        intr_i,
  input  logic [1:0]  mode_i,
  input  logic [4:0]  rs1_addr_i,
  input  logic [4:0]  rs2_addr_i,
  input  logic [4:0]  rd_addr_i,
  input  logic [31:0] rs1_rdata_i,
  input  logic [31:0] rs2_rdata_i,
  input  logic [31:0] rd_wdata_i,
  input  logic [31:0] pc_rdata_i,
  input  logic [31:0] pc_wdata_i,
  input  logic [31:0] mem_addr_i,
  input  logic [3:0]  mem_rmask_i,
  input  logic [3:0]  mem_wmask_i,
  input  logic [31:0] mem_rdata_i,
  input  logic [31:0] mem_wdata_i,
  output int          passed_o,
  output int          failed_o,
  output int          packets_o,
  output logic        timeout_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [63:0] exp_tab [MaxTests][18];
  logic [63:0] exp_rec [18];
  string       test_name [MaxTests];
  int          n_expected = 0;
  int          n_checked = 0;

  task automatic set_expected(input int k, input logic [63:0] value);
    exp_rec[k] = value;
  endtask

  task automatic commit_expected(input string name);
    int k;
    for (k = 0; k < 18; k++) begin
      exp_tab[n_expected][k] = exp_rec[k];
    end
    test_name[n_expected] = name;
    n_expected++;
  endtask

  function automatic string field_name(input int k);
    case (k)
      0: return "order";
      1: return "insn";
      2: return "trap";
      3: return "intr";
      4: return "mode";
      5: return "rs1_addr";
      6: return "rs2_addr";
      7: return "rs1_rdata";
      8: return "rs2_rdata";
      9: return "rd_addr";
      10: return "rd_wdata";
      11: return "pc_rdata";
      12: return "pc_wdata";
      13: return "mem_addr";
      14: return "mem_rmask";
      15: return "mem_wmask";
      16: return "mem_rdata";
      default: return "mem_wdata";
    endcase
  endfunction

  // Field order matches the expected line of the golden file
  function automatic logic [63:0] actual_field(input int k);
    case (k)
      0: return order_i;
      1: return 64'(insn_i);
      2: return 64'(trap_i);
      3: return 64'(intr_i);
      4: return 64'(mode_i);
      5: return 64'(rs1_addr_i);
      6: return 64'(rs2_addr_i);
      7: return 64'(rs1_rdata_i);
      8: return 64'(rs2_rdata_i);
      9: return 64'(rd_addr_i);
      10: return 64'(rd_wdata_i);
      11: return 64'(pc_rdata_i);
      12: return 64'(pc_wdata_i);
      13: return 64'(mem_addr_i);
      14: return 64'(mem_rmask_i);
      15: return 64'(mem_wmask_i);
      16: return 64'(mem_rdata_i);
      default: return 64'(mem_wdata_i);
    endcase
  endfunction

  task automatic compare_packet();
    int k;
    int n_bad;
    int first_bad;
    n_bad = 0;
    first_bad = 0;
    if (n_checked >= n_expected) begin
      $display("Unexpected trace packet with order %0d", order_i);
      failed_o++;
    end else begin
      for (k = 0; k < 18; k++) begin
        if (actual_field(k) !== exp_tab[n_checked][k]) begin
          if (n_bad == 0) begin
            first_bad = k;
          end
          n_bad++;
        end
      end
      if (n_bad == 0) begin
        $display("[PASS] %s", test_name[n_checked]);
        passed_o++;
      end else begin
        $display("[FAIL] %s %s: expected %h, actual %h (%0d fields differ)",
                 test_name[n_checked], field_name(first_bad),
                 exp_tab[n_checked][first_bad], actual_field(first_bad), n_bad);
        failed_o++;
      end
      n_checked++;
      packets_o = n_checked;
    end
  endtask

  initial begin
    int   idle_cycles;
    logic ret_prev;
    passed_o    = 0;
    failed_o    = 0;
    packets_o   = 0;
    timeout_o   = 1'b0;
    idle_cycles = 0;
    while (rst_ni !== 1'b1 && idle_cycles < Timeout) begin
      @(posedge clk);
      idle_cycles++;
    end
    if (rst_ni !== 1'b1) begin
      $display("Reset was never released");
      timeout_o = 1'b1;
      failed_o++;
    end else begin
      // Idle state right after reset
      @(posedge clk);
      if ({valid_i, trap_i, intr_i, order_i, mode_i} !==
          {3'b000, 64'd0, core_pkg::PRIV_LVL_M}) begin
        $display("[FAIL] reset valid/trap/intr/order/mode: expected %h, actual %h",
                 {3'b000, 64'd0, core_pkg::PRIV_LVL_M},
                 {valid_i, trap_i, intr_i, order_i, mode_i});
        failed_o++;
      end else begin
        $display("[PASS] reset");
        passed_o++;
      end
    end
    idle_cycles = 0;
    ret_prev    = ret_i;
    forever begin
      @(posedge clk);
      // Valid is the retire pulse delayed by exactly one cycle
      if (valid_i !== ret_prev) begin
        $display("Packet valid did not follow the retire pulse by one cycle");
        failed_o++;
      end
      ret_prev = ret_i;
      if (valid_i === 1'b1) begin
        compare_packet();
        idle_cycles = 0;
      end else if (n_checked < n_expected && !timeout_o) begin
        idle_cycles++;
        if (idle_cycles > Timeout) begin
          $display("Timeout: no trace packet arrived for test %s", test_name[n_checked]);
          timeout_o = 1'b1;
          failed_o++;
        end
      end
    end
  end

endmodule

// ==== tb/tb_retire_trace.sv ====
//////////////////////////////////////////////////////////////////////
// Retirement trace testbench
// Replays golden records into the DUT, checker compares the packets
//////////////////////////////////////////////////////////////////////

module tb_retire_trace;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DoneTimeout = 100;

  logic                  clk, rst_ni;
  logic                  instr_new_i, instr_ret_i, instr_is_compressed_i, illegal_insn_i;
  logic [31:0]           instr_rdata_i, pc_id_i, pc_if_i;
  logic [15:0]           instr_rdata_c_i;
  logic [4:0]            rs1_addr_i, rs2_addr_i, rd_addr_i;
  logic [31:0]           rs1_rdata_i, rs2_rdata_i, rd_wdata_i;
  logic                  rd_we_i, lsu_data_valid_i, data_we_i, pc_set_i;
  logic [31:0]           mem_addr_i, mem_rdata_i, mem_wdata_i;
  core_pkg::priv_lvl_e   priv_mode_i;
  core_pkg::data_type_e  data_type_i;
  core_pkg::pc_sel_e     pc_mux_i;
  core_pkg::exc_pc_sel_e exc_pc_mux_i;

  logic                  trace_valid_o, trace_trap_o, trace_intr_o;
  logic [63:0]           trace_order_o;
  core_pkg::priv_lvl_e   trace_mode_o;
  logic [31:0]           trace_insn_o, trace_rs1_rdata_o, trace_rs2_rdata_o, trace_rd_wdata_o;
  logic [4:0]            trace_rs1_addr_o, trace_rs2_addr_o, trace_rd_addr_o;
  logic [31:0]           trace_pc_rdata_o, trace_pc_wdata_o, trace_mem_addr_o;
  logic [3:0]            trace_mem_rmask_o, trace_mem_wmask_o;
  logic [31:0]           trace_mem_rdata_o, trace_mem_wdata_o;

  int                    passed, failed, packets;
  logic                  chk_timeout;

  retire_trace i_retire_trace (.*);

  trace_checker i_checker (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .ret_i       (instr_ret_i),
    .valid_i     (trace_valid_o),
    .order_i     (trace_order_o),
    .insn_i      (trace_insn_o),
    .trap_i      (trace_trap_o),
    .intr_i      (trace_intr_o),
    .mode_i      (trace_mode_o),
    .rs1_addr_i  (trace_rs1_addr_o),
    .rs2_addr_i  (trace_rs2_addr_o),
    .rd_addr_i   (trace_rd_addr_o),
    .rs1_rdata_i (trace_rs1_rdata_o),
    .rs2_rdata_i (trace_rs2_rdata_o),
    .rd_wdata_i  (trace_rd_wdata_o),
    .pc_rdata_i  (trace_pc_rdata_o),
    .pc_wdata_i  (trace_pc_wdata_o),
    .mem_addr_i  (trace_mem_addr_o),
    .mem_rmask_i (trace_mem_rmask_o),
    .mem_wmask_i (trace_mem_wmask_o),
    .mem_rdata_i (trace_mem_rdata_o),
    .mem_wdata_i (trace_mem_wdata_o),
    .passed_o    (passed),
    .failed_o    (failed),
    .packets_o   (packets),
    .timeout_o   (chk_timeout)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Next line that is neither a comment nor blank, empty at end of file
  task automatic next_data_line(input int fd, output string line);
    int rc;
    line = "";
    while (line == "" && !$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc == 0 || line.len() < 2 || line.getc(0) == "#") begin
        line = "";
      end
    end
  endtask

  initial begin
    int          fd, n_rec, n_fld, gap, k, wait_cycles;
    logic        tb_error;
    string       line, name;
    logic [63:0] s [21];
    logic [63:0] e [18];
    void'($urandom(46));
    {instr_new_i, instr_ret_i, instr_is_compressed_i, illegal_insn_i} = '0;
    {instr_rdata_i, instr_rdata_c_i, pc_id_i, pc_if_i} = '0;
    {rs1_addr_i, rs2_addr_i, rd_addr_i, rs1_rdata_i, rs2_rdata_i, rd_wdata_i} = '0;
    {rd_we_i, lsu_data_valid_i, data_we_i, pc_set_i} = '0;
    {mem_addr_i, mem_rdata_i, mem_wdata_i} = '0;
    priv_mode_i  = core_pkg::PRIV_LVL_M;
    data_type_i  = core_pkg::DATA_WORD;
    pc_mux_i     = core_pkg::PC_BOOT;
    exc_pc_mux_i = core_pkg::EXC_PC_EXC;
    tb_error     = 1'b0;
    n_rec        = 0;
    rst_ni       = 1'b0;
    repeat (5) @(posedge clk);
    rst_ni <= 1'b1;
    @(posedge clk);

    fd = $fopen("tb/retire_trace_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden file");
      tb_error = 1'b1;
    end else begin
      next_data_line(fd, line);
      while (line != "" && !tb_error) begin
        n_fld = $sscanf(line,
          "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          name, s[0], s[1], s[2], s[3], s[4], s[5], s[6], s[7], s[8], s[9], s[10],
          s[11], s[12], s[13], s[14], s[15], s[16], s[17], s[18], s[19], s[20]);
        next_data_line(fd, line);
        n_fld += $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          e[0], e[1], e[2], e[3], e[4], e[5], e[6], e[7], e[8], e[9], e[10],
          e[11], e[12], e[13], e[14], e[15], e[16], e[17]);
        if (n_fld != 40) begin
          $display("Malformed golden record after %0d records", n_rec);
          tb_error = 1'b1;
        end else begin
          for (k = 0; k < 18; k++) begin
            i_checker.set_expected(k, e[k]);
          end
          i_checker.commit_expected(name);
          // Trap entry kind 1 exception, 2 interrupt, 3 debug entry
          if (s[0] != 0) begin
            pc_set_i     <= 1'b1;
            pc_mux_i     <= core_pkg::PC_EXC;
            exc_pc_mux_i <= core_pkg::exc_pc_sel_e'(s[0][1:0] - 2'd1);
            @(posedge clk);
            pc_set_i     <= 1'b0;
          end
          instr_new_i           <= 1'b1;
          instr_is_compressed_i <= s[1][0];
          illegal_insn_i        <= s[2][0];
          priv_mode_i           <= core_pkg::priv_lvl_e'(s[3][1:0]);
          instr_rdata_i         <= s[4][31:0];
          instr_rdata_c_i       <= s[5][15:0];
          rs1_addr_i            <= s[6][4:0];
          rs2_addr_i            <= s[7][4:0];
          rs1_rdata_i           <= s[8][31:0];
          rs2_rdata_i           <= s[9][31:0];
          rd_addr_i             <= s[10][4:0];
          rd_wdata_i            <= s[11][31:0];
          rd_we_i               <= s[12][0];
          pc_id_i               <= s[19][31:0];
          pc_if_i               <= s[20][31:0];
          @(posedge clk);
          instr_new_i           <= 1'b0;
          // Decode moves on to other operands after this cycle
          instr_is_compressed_i <= ~s[1][0];
          instr_rdata_i         <= ~s[4][31:0];
          instr_rdata_c_i       <= ~s[5][15:0];
          rs1_addr_i            <= ~s[6][4:0];
          rs2_addr_i            <= ~s[7][4:0];
          rs1_rdata_i           <= ~s[8][31:0];
          rs2_rdata_i           <= ~s[9][31:0];
          if (s[13][0]) begin
            lsu_data_valid_i <= 1'b1;
            data_type_i      <= core_pkg::data_type_e'(s[14][1:0]);
            data_we_i        <= s[15][0];
            mem_addr_i       <= s[16][31:0];
            mem_rdata_i      <= s[17][31:0];
            mem_wdata_i      <= s[18][31:0];
            @(posedge clk);
            lsu_data_valid_i <= 1'b0;
            // Bus values after the completed access are stale
            data_type_i      <= core_pkg::data_type_e'(~s[14][1:0]);
            data_we_i        <= ~s[15][0];
            mem_addr_i       <= ~s[16][31:0];
            mem_rdata_i      <= ~s[17][31:0];
            mem_wdata_i      <= ~s[18][31:0];
          end
          instr_ret_i <= 1'b1;
          @(posedge clk);
          instr_ret_i <= 1'b0;
          n_rec++;
          gap = $urandom % 4;
          repeat (gap) @(posedge clk);
          next_data_line(fd, line);
        end
      end
      $fclose(fd);
    end

    wait_cycles = 0;
    while (packets < n_rec && !chk_timeout && wait_cycles < DoneTimeout) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (packets < n_rec) begin
      $display("Timed out waiting for %0d trace packets", n_rec - packets);
      tb_error = 1'b1;
    end
    $display("Tests: %0d passed, %0d failed", passed, failed);
    if (!tb_error && !chk_timeout && failed == 0 && n_rec > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/retire_trace_golden.txt ====
# Stimulus: name trap cmp ill priv insn insn_c rs1 rs2 rs1_data rs2_data rd rd_data rd_we
#   lsu size store mem_addr mem_rdata mem_wdata pc_id pc_if (trap 0 none 1 exc 2 irq 3 debug)
# Expected: order insn trap intr mode rs1 rs2 rs1_data rs2_data rd rd_data pc_rdata pc_wdata
#   mem_addr rmask wmask mem_rdata mem_wdata, all values hex
add_x3 0 0 0 3 002081b3 0 1 2 11 22 3 33 1 0 0 0 0 0 0 80 84
  0 002081b3 0 0 3 1 2 11 22 3 33 80 84 0 0 0 0 0
lw_word 0 0 0 3 0080a283 0 1 0 1000 0 5 deadbeef 1 1 0 0 1008 deadbeef 0 84 88
  1 0080a283 0 0 3 1 0 1000 0 5 deadbeef 84 88 1008 f 0 deadbeef 0
sh_half 0 0 0 3 00209223 0 1 2 2000 beef 4 55 0 1 1 1 2004 0 beef 88 8c
  2 00209223 0 0 3 1 2 2000 beef 0 0 88 8c 2004 3 3 0 beef
c_addi 0 1 0 3 12345678 0505 a 0 42 0 a 43 1 0 0 0 0 0 0 8c 8e
  3 00000505 0 0 3 a 0 42 0 a 43 8c 8e 2004 3 3 0 beef
trap_csr_x0 1 0 0 3 34011073 0 2 0 99 0 0 77 1 1 2 0 3003 5a 0 100 104
  4 34011073 0 1 3 2 0 99 0 0 0 100 104 3003 1 0 5a 0
illegal_user 0 0 1 0 ffffffff 0 1f 1e a5 5a 7 9 0 0 0 0 0 0 0 104 200
  5 ffffffff 1 0 0 1f 1e a5 5a 0 0 104 200 3003 1 0 5a 0
irq_sw 2 0 0 3 00112023 0 2 1 4000 cafe 0 0 0 1 0 1 4000 0 cafe 300 304
  6 00112023 0 1 3 2 1 4000 cafe 0 0 300 304 4000 f f 0 cafe
dbg_c_nop 3 1 0 3 0 0001 0 0 0 0 0 0 0 0 0 0 0 0 0 304 306
  7 00000001 0 0 3 0 0 0 0 0 0 304 306 4000 f f 0 cafe

// ==== list.f ====
src/core_pkg.sv
src/trace_pkg.sv
src/operand_if.sv
src/trace_ctrl_tracker.sv
src/trace_operand_capture.sv
src/trace_packer.sv
src/retire_trace.sv
tb/trace_checker.sv
tb/tb_retire_trace.sv
